//--- dv/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
   parameter int PERIOD_NS = 100
) (
   output logic clk
);

   // free running, starts low
   initial begin
      clk = 1'b0;
      forever begin
         #(PERIOD_NS / 2) clk = ~clk;
      end
   end

endmodule

`default_nettype wire

//--- dv/tb_fifo_tests.svh
`ifndef TB_FIFO_TESTS_SVH
`define TB_FIFO_TESTS_SVH

task automatic after_reset();
   @(negedge clk);
   compare_outputs();
   check_flags(flags, make_flags(1'b1, 1'b0));
   check_level(level, '0);
   check_rdata(r_data, '0);
endtask

// one word in, four bytes out, lane 0 first
task automatic single_word_order();
   logic [W_DATA_W-1:0] word;
   int                  i;
   word = $urandom();
   run_cycle(1'b1, word, 1'b0);
   for (i = 0; i < LANES; i++) begin
      run_cycle(1'b0, '0, 1'b1);
      check_level(level, (ADDR_W+1)'(LANES - i));
      if (i > 0) begin
         check_rdata(r_data, word[(i-1)*R_DATA_W +: R_DATA_W]);
      end
   end
   run_cycle(1'b0, '0, 1'b0);
   check_rdata(r_data, word[(LANES-1)*R_DATA_W +: R_DATA_W]);
   check_level(level, '0);
   check_flags(flags, make_flags(1'b1, 1'b0));
endtask

task automatic fill_to_full();
   int i;
   for (i = 0; i < DEPTH / LANES; i++) begin
      run_cycle(1'b1, $urandom(), 1'b0);
      // one word short of capacity, not yet full
      if (i == DEPTH / LANES - 1) begin
         check_level(level, (ADDR_W+1)'(DEPTH - LANES));
         check_flags(flags, make_flags(1'b0, 1'b0));
      end
   end
   // this one lands on a full FIFO
   run_cycle(1'b1, 32'hdead_beef, 1'b0);
   check_level(level, (ADDR_W+1)'(DEPTH));
   check_flags(flags, make_flags(1'b0, 1'b1));
   run_cycle(1'b0, '0, 1'b0);
   check_level(level, (ADDR_W+1)'(DEPTH));
   check_flags(flags, make_flags(1'b0, 1'b1));
endtask

task automatic drain_to_empty();
   logic [R_DATA_W-1:0] last;
   int                  i;
   for (i = 0; i < DEPTH; i++) begin
      run_cycle(1'b0, '0, 1'b1);
   end
   // last byte comes back here, extra read goes out
   run_cycle(1'b0, '0, 1'b1);
   last = exp_rdata;
   check_level(level, '0);
   check_flags(flags, make_flags(1'b1, 1'b0));
   run_cycle(1'b0, '0, 1'b0);
   check_rdata(r_data, last);
   check_level(level, '0);
   check_flags(flags, make_flags(1'b1, 1'b0));
endtask

// write and read every cycle, flags decide what is taken
task automatic random_pairs();
   int i;
   for (i = 0; i < 100; i++) begin
      run_cycle(1'b1, $urandom(), 1'b1);
   end
   for (i = 0; i < DEPTH + 2; i++) begin
      run_cycle(1'b0, '0, 1'b1);
   end
   run_cycle(1'b0, '0, 1'b0);
   check_level(level, '0);
   check_flags(flags, make_flags(1'b1, 1'b0));
endtask

`endif

//--- dv/tb_fifo_asym.sv
`timescale 1ns/100ps
`default_nettype none

`include "fifo_defs.svh"

module tb_fifo_asym
   import fifo_pkg::*;
();

   localparam int W_DATA_W = `FIFO_W_DATA_W;
   localparam int R_DATA_W = `FIFO_R_DATA_W;
   localparam int ADDR_W = `FIFO_ADDR_W;
   // bytes per write word, capacity in bytes
   localparam int LANES = W_DATA_W / R_DATA_W;
   localparam int DEPTH = 2 ** ADDR_W;
   // all tests take a few hundred cycles
   localparam int TEST_CYCLES = 500;
   localparam int MAX_CYCLES = 4 * TEST_CYCLES;

   logic                 clk;
   logic                 rst;
   logic                 w_en;
   logic [W_DATA_W-1:0]  w_data;
   logic                 r_en;
   logic [R_DATA_W-1:0]  r_data;
   fifo_flags_t          flags;
   logic [ADDR_W:0]      level;

   // reference model, one byte per entry
   logic [R_DATA_W-1:0]  model_q[$];
   logic [R_DATA_W-1:0]  exp_rdata;
   // request driven last cycle, taken by the DUT at the next edge
   logic                 pend_we;
   logic [W_DATA_W-1:0]  pend_wd;
   logic                 pend_re;
   int                   cycle_count = 0;

   tb_clock_gen #(
      .PERIOD_NS (100)
   ) u_clock_gen (
      .clk (clk)
   );

   fifo_asym_top #(
      .W_DATA_W (W_DATA_W),
      .R_DATA_W (R_DATA_W),
      .ADDR_W   (ADDR_W)
   ) DUT (
      .clk    (clk),
      .rst    (rst),
      .w_en   (w_en),
      .w_data (w_data),
      .r_en   (r_en),
      .r_data (r_data),
      .flags  (flags),
      .level  (level)
   );

   task automatic fail_run();
      $display("Simulation failed");
      $fatal(1, "stopped at the first failure");
   endtask

   task automatic check_rdata(input logic [R_DATA_W-1:0] act, input logic [R_DATA_W-1:0] exp);
      if (act !== exp) begin
         $display("error: r_data is 0x%h, expected 0x%h", act, exp);
         fail_run();
      end
   endtask

   task automatic check_flags(input fifo_flags_t act, input fifo_flags_t exp);
      if (act !== exp) begin
         $display("error: flags {empty,full} is 0x%h, expected 0x%h", act, exp);
         fail_run();
      end
   endtask

   task automatic check_level(input logic [ADDR_W:0] act, input logic [ADDR_W:0] exp);
      if (act !== exp) begin
         $display("error: level is 0x%h, expected 0x%h", act, exp);
         fail_run();
      end
   endtask

   function automatic fifo_flags_t make_flags(input logic empty, input logic full);
      fifo_flags_t f;
      f.empty = empty;
      f.full  = full;
      return f;
   endfunction

   // empty below one byte, full when a whole word no longer fits
   function automatic fifo_flags_t model_flags();
      fifo_flags_t f;
      f.empty = (model_q.size() < 1);
      f.full  = (model_q.size() > DEPTH - LANES);
      return f;
   endfunction

   task automatic update_model(input logic we, input logic [W_DATA_W-1:0] wd, input logic re);
      fifo_flags_t f;
      logic        wr_ok;
      logic        rd_ok;
      int          i;
      f = model_flags();
      wr_ok = we && !f.full;
      rd_ok = re && !f.empty;
      if (rd_ok) begin
         exp_rdata = model_q.pop_front();
      end
      // lane 0 goes in first
      if (wr_ok) begin
         for (i = 0; i < LANES; i++) begin
            model_q.push_back(wd[i*R_DATA_W +: R_DATA_W]);
         end
      end
   endtask

   task automatic compare_outputs();
      check_rdata(r_data, exp_rdata);
      check_flags(flags, model_flags());
      check_level(level, (ADDR_W+1)'(model_q.size()));
   endtask

   // drive one request, then check what the previous one did
   task automatic run_cycle(input logic we, input logic [W_DATA_W-1:0] wd, input logic re);
      @(posedge clk);
      w_en   <= we;
      w_data <= wd;
      r_en   <= re;
      @(negedge clk);
      update_model(pend_we, pend_wd, pend_re);
      compare_outputs();
      pend_we = we;
      pend_wd = wd;
      pend_re = re;
   endtask

   `include "tb_fifo_tests.svh"

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= MAX_CYCLES) begin
         $display("timeout: tests still running after %0d cycles", MAX_CYCLES);
         fail_run();
      end
   end

   initial begin
      void'($urandom(32'hc2ded51a));
      rst         <= 1'b1;
      w_en        <= 1'b0;
      w_data      <= '0;
      r_en        <= 1'b0;
      pend_we     = 1'b0;
      pend_wd     = '0;
      pend_re     = 1'b0;
      exp_rdata   = '0;
      repeat (5) @(posedge clk);
      rst <= 1'b0;

      after_reset();
      single_word_order();
      fill_to_full();
      drain_to_empty();
      random_pairs();

      $display("Simulation completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

//--- include/fifo_defs.svh
`ifndef FIFO_DEFS_SVH
`define FIFO_DEFS_SVH

// write side word width in bits
`define FIFO_W_DATA_W 32

// read side word width in bits
`define FIFO_R_DATA_W 8

// address width in narrow units, 64 units deep
`define FIFO_ADDR_W 6

`endif

//--- run_sim.sh
#!/bin/sh
# build and run the FIFO testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/100ps -j 0 \
   --top-module tb_fifo_asym -f src.f -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
   echo "result: FAIL"
   exit 1
fi
if [ "$status" -ne 0 ]; then
   echo "result: simulator exited with status $status"
   exit "$status"
fi
echo "result: PASS"

//--- src.f
+incdir+include
+incdir+dv
verilog/fifo_pkg.sv
verilog/ram_2p_bank.sv
verilog/ram_2p_asym.sv
verilog/fifo_sync_asym.sv
verilog/fifo_asym_top.sv
dv/tb_clock_gen.sv
dv/tb_fifo_asym.sv

//--- verilog/fifo_asym_top.sv
`timescale 1ns/100ps
`default_nettype none

module fifo_asym_top
   import fifo_pkg::*;
#(
   parameter int W_DATA_W = DEF_W_DATA_W,
   parameter int R_DATA_W = DEF_R_DATA_W,
   parameter int ADDR_W = DEF_ADDR_W
) (
   input  wire                   clk,
   input  wire                   rst,

   input  wire                   w_en,
   input  wire [W_DATA_W-1:0]    w_data,

   input  wire                   r_en,
   output logic [R_DATA_W-1:0]   r_data,

   output fifo_flags_t           flags,
   output logic [ADDR_W:0]       level
);

   localparam int MAX_W = max_w(W_DATA_W, R_DATA_W);
   localparam int MIN_W = min_w(W_DATA_W, R_DATA_W);
   localparam int N = MAX_W / MIN_W;
   localparam int MIN_ADDR_W = ADDR_W - lane_w(W_DATA_W, R_DATA_W);

   logic [N-1:0]           ext_mem_w_en;
   logic [MIN_ADDR_W-1:0]  ext_mem_w_addr;
   logic [N*MIN_W-1:0]     ext_mem_w_data;
   logic [N-1:0]           ext_mem_r_en;
   logic [MIN_ADDR_W-1:0]  ext_mem_r_addr;
   logic [N*MIN_W-1:0]     ext_mem_r_data;

   fifo_sync_asym #(
      .W_DATA_W (W_DATA_W),
      .R_DATA_W (R_DATA_W),
      .ADDR_W   (ADDR_W)
   ) u_fifo (
      .clk            (clk),
      .rst            (rst),
      .w_en           (w_en),
      .w_data         (w_data),
      .r_en           (r_en),
      .r_data         (r_data),
      .flags          (flags),
      .level          (level),
      .ext_mem_w_en   (ext_mem_w_en),
      .ext_mem_w_addr (ext_mem_w_addr),
      .ext_mem_w_data (ext_mem_w_data),
      .ext_mem_r_en   (ext_mem_r_en),
      .ext_mem_r_addr (ext_mem_r_addr),
      .ext_mem_r_data (ext_mem_r_data)
   );

   // one narrow bank per lane, rows shared
   for (genvar i = 0; i < N; i++) begin : g_bank
      ram_2p_bank #(
         .DATA_W (MIN_W),
         .ADDR_W (MIN_ADDR_W)
      ) u_bank (
         .clk    (clk),
         .w_en   (ext_mem_w_en[i]),
         .w_addr (ext_mem_w_addr),
         .w_data (ext_mem_w_data[i*MIN_W +: MIN_W]),
         .r_en   (ext_mem_r_en[i]),
         .r_addr (ext_mem_r_addr),
         .r_data (ext_mem_r_data[i*MIN_W +: MIN_W])
      );
   end

endmodule

`default_nettype wire

//--- verilog/fifo_pkg.sv
`default_nettype none

`include "fifo_defs.svh"

package fifo_pkg;

   // default configuration for the top level
   parameter int DEF_W_DATA_W = `FIFO_W_DATA_W;
   parameter int DEF_R_DATA_W = `FIFO_R_DATA_W;
   parameter int DEF_ADDR_W   = `FIFO_ADDR_W;

   function automatic int max_w(input int a, input int b);
      return (a > b) ? a : b;
   endfunction

   function automatic int min_w(input int a, input int b);
      return (a < b) ? a : b;
   endfunction

   // log2 of the wide to narrow ratio
   function automatic int lane_w(input int a, input int b);
      return $clog2(max_w(a, b) / min_w(a, b));
   endfunction

   typedef struct packed {
      logic empty;
      logic full;
   } fifo_flags_t;

endpackage

`default_nettype wire

//--- verilog/fifo_sync_asym.sv
`timescale 1ns/100ps
`default_nettype none

module fifo_sync_asym
   import fifo_pkg::*;
#(
   parameter int W_DATA_W = DEF_W_DATA_W,
   parameter int R_DATA_W = DEF_R_DATA_W,
   // depth in narrow units
   parameter int ADDR_W = DEF_ADDR_W,
   localparam int MAX_W = max_w(W_DATA_W, R_DATA_W),
   localparam int MIN_W = min_w(W_DATA_W, R_DATA_W),
   localparam int N = MAX_W / MIN_W,
   localparam int L_W = lane_w(W_DATA_W, R_DATA_W),
   // bank row width, the wide side address
   localparam int MIN_ADDR_W = ADDR_W - L_W,
   localparam int W_ADDR_W = (W_DATA_W > R_DATA_W) ? MIN_ADDR_W : ADDR_W,
   localparam int R_ADDR_W = (R_DATA_W > W_DATA_W) ? MIN_ADDR_W : ADDR_W
) (
   input  wire                      clk,
   input  wire                      rst,

   // user write side
   input  wire                      w_en,
   input  wire [W_DATA_W-1:0]       w_data,

   // user read side
   input  wire                      r_en,
   output logic [R_DATA_W-1:0]      r_data,

   // status
   output fifo_flags_t              flags,
   output logic [ADDR_W:0]          level,

   // external memory, write side
   output logic [N-1:0]             ext_mem_w_en,
   output logic [MIN_ADDR_W-1:0]    ext_mem_w_addr,
   output logic [N*MIN_W-1:0]       ext_mem_w_data,

   // external memory, read side
   output logic [N-1:0]             ext_mem_r_en,
   output logic [MIN_ADDR_W-1:0]    ext_mem_r_addr,
   input  wire [N*MIN_W-1:0]        ext_mem_r_data
);

   localparam logic [ADDR_W:0] FIFO_SIZE = (ADDR_W+1)'(2 ** ADDR_W);
   // level steps in narrow units
   localparam logic [ADDR_W:0] W_INCR = (ADDR_W+1)'((W_DATA_W > R_DATA_W) ? N : 1);
   localparam logic [ADDR_W:0] R_INCR = (ADDR_W+1)'((R_DATA_W > W_DATA_W) ? N : 1);

   logic                 w_en_int;
   logic                 r_en_int;
   logic [W_ADDR_W-1:0]  w_ptr;
   logic [R_ADDR_W-1:0]  r_ptr;
   logic [ADDR_W:0]      level_nxt;
   fifo_flags_t          flags_nxt;

   // requests past the flags are dropped
   assign w_en_int = w_en & ~flags.full;
   assign r_en_int = r_en & ~flags.empty;

   // pointers count in each side's own word size and wrap on overflow
   always_ff @(posedge clk) begin
      if (rst) begin
         w_ptr <= '0;
         r_ptr <= '0;
      end else begin
         if (w_en_int) begin
            w_ptr <= w_ptr + 1'b1;
         end
         if (r_en_int) begin
            r_ptr <= r_ptr + 1'b1;
         end
      end
   end

   always_comb begin
      level_nxt = level;
      if (w_en_int) begin
         level_nxt = level_nxt + W_INCR;
      end
      if (r_en_int) begin
         level_nxt = level_nxt - R_INCR;
      end
   end

   // empty when not a whole read word is left, full when a write word won't fit
   always_comb begin
      flags_nxt.empty = (level_nxt < R_INCR);
      flags_nxt.full  = (level_nxt > (FIFO_SIZE - W_INCR));
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         level       <= '0;
         flags.empty <= 1'b1;
         flags.full  <= 1'b0;
      end else begin
         level <= level_nxt;
         flags <= flags_nxt;
      end
   end

   ram_2p_asym #(
      .W_DATA_W (W_DATA_W),
      .R_DATA_W (R_DATA_W),
      .ADDR_W   (ADDR_W)
   ) u_ram_2p_asym (
      .clk            (clk),
      .rst            (rst),
      .w_en           (w_en_int),
      .w_addr         (w_ptr),
      .w_data         (w_data),
      .r_en           (r_en_int),
      .r_addr         (r_ptr),
      .r_data         (r_data),
      .ext_mem_w_en   (ext_mem_w_en),
      .ext_mem_w_addr (ext_mem_w_addr),
      .ext_mem_w_data (ext_mem_w_data),
      .ext_mem_r_en   (ext_mem_r_en),
      .ext_mem_r_addr (ext_mem_r_addr),
      .ext_mem_r_data (ext_mem_r_data)
   );

endmodule

`default_nettype wire

//--- verilog/ram_2p_asym.sv
`timescale 1ns/100ps
`default_nettype none

module ram_2p_asym
   import fifo_pkg::*;
#(
   parameter int W_DATA_W = DEF_W_DATA_W,
   parameter int R_DATA_W = DEF_R_DATA_W,
   parameter int ADDR_W = DEF_ADDR_W,
   localparam int MAX_W = max_w(W_DATA_W, R_DATA_W),
   localparam int MIN_W = min_w(W_DATA_W, R_DATA_W),
   localparam int N = MAX_W / MIN_W,
   localparam int L_W = lane_w(W_DATA_W, R_DATA_W),
   localparam int MIN_ADDR_W = ADDR_W - L_W,
   localparam int W_ADDR_W = (W_DATA_W > R_DATA_W) ? MIN_ADDR_W : ADDR_W,
   localparam int R_ADDR_W = (R_DATA_W > W_DATA_W) ? MIN_ADDR_W : ADDR_W
) (
   input  wire                      clk,
   input  wire                      rst,

   input  wire                      w_en,
   input  wire [W_ADDR_W-1:0]       w_addr,
   input  wire [W_DATA_W-1:0]       w_data,

   input  wire                      r_en,
   input  wire [R_ADDR_W-1:0]       r_addr,
   output logic [R_DATA_W-1:0]      r_data,

   // banks, one lane of MIN_W bits each
   output logic [N-1:0]             ext_mem_w_en,
   output logic [MIN_ADDR_W-1:0]    ext_mem_w_addr,
   output logic [N*MIN_W-1:0]       ext_mem_w_data,
   output logic [N-1:0]             ext_mem_r_en,
   output logic [MIN_ADDR_W-1:0]    ext_mem_r_addr,
   input  wire [N*MIN_W-1:0]        ext_mem_r_data
);

   logic                 r_valid;
   logic [R_DATA_W-1:0]  sel_data;
   logic [R_DATA_W-1:0]  r_hold;

   generate
      if (W_DATA_W > R_DATA_W) begin : g_wide_write
         logic [L_W-1:0] r_lane;
         logic [L_W-1:0] r_lane_q;

         // wide write hits every bank on the same row
         assign ext_mem_w_en   = {N{w_en}};
         assign ext_mem_w_addr = w_addr;
         assign ext_mem_w_data = w_data;

         // low address bits pick the lane
         assign r_lane         = r_addr[L_W-1:0];
         assign ext_mem_r_addr = r_addr[ADDR_W-1:L_W];
         assign ext_mem_r_en   = N'(r_en) << r_lane;

         always_ff @(posedge clk) begin
            if (rst) begin
               r_lane_q <= '0;
            end else if (r_en) begin
               r_lane_q <= r_lane;
            end
         end

         assign sel_data = ext_mem_r_data[r_lane_q*MIN_W +: MIN_W];
      end else if (R_DATA_W > W_DATA_W) begin : g_wide_read
         // narrow write goes to one bank, data copied on all lanes
         assign ext_mem_w_addr = w_addr[ADDR_W-1:L_W];
         assign ext_mem_w_en   = N'(w_en) << w_addr[L_W-1:0];
         assign ext_mem_w_data = {N{w_data}};

         assign ext_mem_r_en   = {N{r_en}};
         assign ext_mem_r_addr = r_addr;
         // lane 0 in the low bits
         assign sel_data       = ext_mem_r_data;
      end else begin : g_symmetric
         assign ext_mem_w_en   = w_en;
         assign ext_mem_w_addr = w_addr;
         assign ext_mem_w_data = w_data;
         assign ext_mem_r_en   = r_en;
         assign ext_mem_r_addr = r_addr;
         assign sel_data       = ext_mem_r_data;
      end
   endgenerate

   // bank data lands one cycle after the strobe
   always_ff @(posedge clk) begin
      if (rst) begin
         r_valid <= 1'b0;
         r_hold  <= '0;
      end else begin
         r_valid <= r_en;
         if (r_valid) begin
            r_hold <= sel_data;
         end
      end
   end

   // keep the last word until the next read returns
   assign r_data = r_valid ? sel_data : r_hold;

endmodule

`default_nettype wire

//--- verilog/ram_2p_bank.sv
`timescale 1ns/100ps
`default_nettype none

module ram_2p_bank #(
   parameter int DATA_W = 8,
   parameter int ADDR_W = 4
) (
   input  wire                clk,

   input  wire                w_en,
   input  wire [ADDR_W-1:0]   w_addr,
   input  wire [DATA_W-1:0]   w_data,

   input  wire                r_en,
   input  wire [ADDR_W-1:0]   r_addr,
   output logic [DATA_W-1:0]  r_data
);

   logic [DATA_W-1:0] mem [2**ADDR_W];

   always_ff @(posedge clk) begin
      if (w_en) begin
         mem[w_addr] <= w_data;
      end
   end

   // output register only moves on a read strobe
   always_ff @(posedge clk) begin
      if (r_en) begin
         r_data <= mem[r_addr];
      end
   end

endmodule

`default_nettype wire
